// ==== files.f ====
logic/pd_pkg.sv
logic/instr_decode.sv
logic/jump_cond.sv
logic/phase_seq.sv
logic/pd.sv
verification/pd_checker.sv
verification/pd_tb.sv

// ==== Bender.yml ====
package:
  name: pd

sources:
  - logic/pd_pkg.sv
  - logic/instr_decode.sv
  - logic/jump_cond.sv
  - logic/phase_seq.sv
  - logic/pd.sv
  - target: test
    files:
      - verification/pd_checker.sv
      - verification/pd_tb.sv

// ==== verification/pd_tb.sv ====
`timescale 1ns/1ps
/*
	Testbench for pd built with io_user_illegal = 1
	q and r0 are held for the whole of each instruction
*/

module pd_tb import pd_pkg::*; ();

	localparam int  period  = 4;	// ns
	localparam int  n_rand  = 150;	// Random instructions
	localparam int  n_limit = 200;	// Instructions covered by the watchdog
	localparam time timeout = n_limit * 8 * period;
	localparam bit  io_ill  = 1'b1;	// IN/OU illegal in user mode

	logic            strob1;
	logic            rst_n;
	logic [0:ir_w-1] w;
	logic            w_ir;
	logic            si1;
	logic            q;
	logic [0:r0_w-1] r0;
	logic [0:ir_w-1] ir;
	cls_t            cls;
	logic            xi;
	logic            nef;
	phase_t          phase;
	logic            busy;
	logic            ekc;

	phase_t exp_ph[$];	// Expected phases from cycle 1 on

	pd #(
		.io_user_illegal(io_ill)
	) dut_i (
		.strob1(strob1),
		.rst_n (rst_n),
		.w     (w),
		.w_ir  (w_ir),
		.si1   (si1),
		.q     (q),
		.r0    (r0),
		.ir    (ir),
		.cls   (cls),
		.xi    (xi),
		.nef   (nef),
		.phase (phase),
		.busy  (busy),
		.ekc   (ekc)
	);

	bind pd pd_checker chk_i (
		.strob1(strob1),
		.rst_n (rst_n),
		.w_ir  (w_ir),
		.start (start),
		.ir    (ir),
		.phase (phase),
		.busy  (busy),
		.ekc   (ekc),
		.nef   (nef)
	);

	initial begin
		strob1 = 1'b0;
		forever #(period / 2) strob1 = ~strob1;
	end

	initial begin
		#(timeout);
		$display("Run timed out after %0t, a sequence never finished", $time);
		$display("Result: FAILED");
		$fatal(1, "Watchdog expired");
	end

	// Bound assertion failures stop the run at once
	always @(negedge strob1) begin
		if (dut_i.chk_i.fail_cnt != 0) begin
			$display("A bound assertion failed at %0t", $time);
			$display("Result: FAILED");
			$fatal(1, "Checker reported an error");
		end
	end

	task automatic check_val(input string name, input logic [15:0] exp_v,
			input logic [15:0] act_v);
		assert (act_v === exp_v) else begin
			$display("FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp_v, act_v);
			$display("Result: FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic expect_idle(input logic [0:ir_w-1] exp_ir);
		check_val("phase", PH_IDLE, phase);
		check_val("busy", 1'b0, busy);
		check_val("ekc", 1'b0, ekc);
		check_val("ir", exp_ir, ir);
	endtask

	function automatic logic [0:ir_w-1] make_word(input logic [5:0] op,
			input logic [2:0] a, input logic [2:0] b, input logic [2:0] c);
		return {op, 1'b0, a, b, c};	// D left at zero
	endfunction

	// Expected response from the decoder rules
	task automatic ref_model(input logic [0:ir_w-1] word, input logic si1v, input logic qv,
			input logic [0:r0_w-1] f, output logic [0:ir_w-1] exp_ir,
			output cls_t exp_cls, output logic exp_xi, output logic exp_nef);
		logic [5:0] op;
		logic [2:0] a;
		logic       taken;
		exp_ir = word;
		if (si1v)
			exp_ir[0:1] = 2'b00;
		op = exp_ir[0:5];
		a  = exp_ir[7:9];
		if (op >= 6'o20 && op <= 6'o57)
			exp_cls = CLS_ARG;
		else if (op >= 6'o60 && op <= 6'o67)
			exp_cls = CLS_SHORT;
		else if (op == 6'o70)
			exp_cls = CLS_JUMP;
		else if (op == 6'o73)
			exp_cls = CLS_SYS;
		else if (op == 6'o74 || op == 6'o75)
			exp_cls = CLS_IO;
		else
			exp_cls = CLS_ILL;
		exp_xi = (exp_cls == CLS_ILL) || (exp_cls == CLS_SYS && qv) ||
			(exp_cls == CLS_IO && qv && io_ill);
		case (a)
			3'd1:    taken = f[4];	// L
			3'd2:    taken = f[5];	// E
			3'd3:    taken = f[6];	// G
			3'd4:    taken = f[0];	// Z
			3'd5:    taken = f[1];	// M
			3'd6:    taken = !f[5];
			default: taken = 1'b1;	// UJ and LJ
		endcase
		exp_nef = exp_xi || (exp_cls == CLS_JUMP && !taken);
		exp_ph.delete();
		if (exp_nef) begin
			exp_ph.push_back(PH_END);
		end else begin
			if ((exp_cls == CLS_ARG || exp_cls == CLS_JUMP) && exp_ir[13:15] == 3'd0)
				exp_ph.push_back(PH_WP);
			if (exp_ir[10:12] != 3'd0)
				exp_ph.push_back(PH_WA);
			exp_ph.push_back(PH_WE);
			exp_ph.push_back(PH_END);
		end
	endtask

	// Load one word and walk its sequence with w_ir held up if noisy
	task automatic run_instr(input logic [0:ir_w-1] word, input logic si1v, input logic qv,
			input logic [0:r0_w-1] f, input logic noisy);
		logic [0:ir_w-1] exp_ir;
		cls_t            exp_cls;
		logic            exp_xi;
		logic            exp_nef;
		ref_model(word, si1v, qv, f, exp_ir, exp_cls, exp_xi, exp_nef);
		@(negedge strob1);
		w    = word;
		w_ir = 1'b1;
		si1  = si1v;
		q    = qv;
		r0   = f;
		@(negedge strob1);	// IR loaded at cycle 0
		si1  = 1'b0;
		w    = ~word;
		w_ir = noisy;
		check_val("ir", exp_ir, ir);
		check_val("cls", exp_cls, cls);
		check_val("xi", exp_xi, xi);
		check_val("nef", exp_nef, nef);
		check_val("phase", PH_IDLE, phase);
		for (int i = 0; i < exp_ph.size(); i++) begin
			@(negedge strob1);
			check_val("phase", exp_ph[i], phase);
			check_val("busy", 1'b1, busy);
			check_val("ekc", exp_ph[i] == PH_END, ekc);
			check_val("ir", exp_ir, ir);	// Held under back-pressure
			if (exp_ph[i] == PH_END)
				w_ir = 1'b0;	// Drop before busy falls
		end
		@(negedge strob1);
		expect_idle(exp_ir);
	endtask

	initial begin
		logic [0:ir_w-1] word;
		void'($urandom(27));
		rst_n = 1'b0;
		w     = '0;
		w_ir  = 1'b0;
		si1   = 1'b0;
		q     = 1'b0;
		r0    = '0;
		repeat (3) begin
			@(negedge strob1);
			expect_idle('0);
		end
		rst_n = 1'b1;
		@(negedge strob1);
		expect_idle('0);
		run_instr(make_word(6'o20, 3'd1, 3'd0, 3'd0), 1'b0, 1'b0, '0, 1'b0);	// WP WE
		run_instr(make_word(6'o41, 3'd2, 3'd2, 3'd0), 1'b0, 1'b1, '0, 1'b1);	// WP WA WE
		run_instr(make_word(6'o57, 3'd0, 3'd0, 3'd3), 1'b0, 1'b0, '0, 1'b0);	// WE only
		run_instr(make_word(6'o61, 3'd4, 3'd1, 3'd0), 1'b0, 1'b0, '0, 1'b1);	// WA WE
		run_instr(make_word(6'o67, 3'd4, 3'd0, 3'd0), 1'b0, 1'b1, '0, 1'b0);
		for (int a = 0; a < 8; a++)
			run_instr(make_word(op_jump, 3'(a), 3'd0, 3'd0), 1'b0, 1'b0,
				r0_w'($urandom), 1'(a));
		run_instr(make_word(op_sys, 3'd0, 3'd0, 3'd0), 1'b0, 1'b0, '0, 1'b0);
		run_instr(make_word(op_sys, 3'd0, 3'd0, 3'd0), 1'b0, 1'b1, '0, 1'b1);	// User mode
		run_instr(make_word(op_in, 3'd1, 3'd0, 3'd2), 1'b0, 1'b0, '0, 1'b0);
		run_instr(make_word(op_in, 3'd1, 3'd0, 3'd2), 1'b0, 1'b1, '0, 1'b0);
		run_instr(make_word(op_ou, 3'd2, 3'd3, 3'd0), 1'b0, 1'b1, '0, 1'b1);
		run_instr(make_word(6'o05, 3'd0, 3'd0, 3'd0), 1'b0, 1'b0, '0, 1'b0);
		run_instr(make_word(6'o71, 3'd0, 3'd5, 3'd0), 1'b0, 1'b0, '0, 1'b0);
		run_instr(make_word(6'o45, 3'd3, 3'd0, 3'd0), 1'b1, 1'b0, '0, 1'b0);	// Invalidated
		for (int n = 0; n < n_rand; n++) begin
			word = ir_w'($urandom);
			run_instr(word, ($urandom % 8) == 0, 1'($urandom), r0_w'($urandom),
				($urandom % 4) == 0);
		end
		if (dut_i.chk_i.fail_cnt == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("Result: FAILED");
			$fatal(1, "Checker reported an error");
		end
	end

endmodule

// ==== verification/pd_checker.sv ====
`timescale 1ns/1ps
/*
	Concurrent checks of the W->IR handshake and the phase order bound into pd
	All checks idle during reset and each failure adds to fail_cnt
*/

module pd_checker import pd_pkg::*; (
	input logic            strob1,
	input logic            rst_n,
	input logic            w_ir,
	input logic            start,	// Internal load-accept pulse of pd
	input logic [0:ir_w-1] ir,
	input phase_t          phase,
	input logic            busy,
	input logic            ekc,
	input logic            nef
);

	int fail_cnt = 0;	// Failed assertions so far

	// IR frozen across every edge seen with busy high
	hold_ir: assert property (@(posedge strob1) disable iff (!rst_n)
		busy |=> $stable(ir))
		else begin
			fail_cnt++;
			$error("IR changed while busy");
		end

	// A strobe in idle starts a sequence two edges later
	load_ok: assert property (@(posedge strob1) disable iff (!rst_n)
		w_ir && !busy && !start |=> ##1 busy)
		else begin
			fail_cnt++;
			$error("W->IR in idle did not start a sequence");
		end

	// Cycle end strobe lasts one cycle
	ekc_one: assert property (@(posedge strob1) disable iff (!rst_n)
		ekc |=> !ekc && phase == PH_IDLE)
		else begin
			fail_cnt++;
			$error("ekc not a single cycle followed by idle");
		end

	end_one: assert property (@(posedge strob1) disable iff (!rst_n)
		phase == PH_END |=> phase == PH_IDLE)
		else begin
			fail_cnt++;
			$error("Cycle end not followed by idle");
		end

	wp_next: assert property (@(posedge strob1) disable iff (!rst_n)
		phase == PH_WP |=> phase inside {PH_WA, PH_WE})
		else begin
			fail_cnt++;
			$error("Bad phase after WP");
		end

	wa_next: assert property (@(posedge strob1) disable iff (!rst_n)
		phase == PH_WA |=> phase == PH_WE)
		else begin
			fail_cnt++;
			$error("Bad phase after WA");
		end

	we_next: assert property (@(posedge strob1) disable iff (!rst_n)
		phase == PH_WE |=> phase == PH_END)
		else begin
			fail_cnt++;
			$error("Bad phase after WE");
		end

	// Ineffective goes straight to the end
	nef_end: assert property (@(posedge strob1) disable iff (!rst_n)
		start && nef |=> phase == PH_END)
		else begin
			fail_cnt++;
			$error("Ineffective instruction did not end at once");
		end

endmodule

// ==== logic/pd.sv ====
`timescale 1ns/1ps
/*
	Instruction decoder top, reduced to six classes and three phases
	q and r0 must not change while busy is high
*/

module pd import pd_pkg::*; #(
	parameter bit io_user_illegal = 1'b1	// 1 makes IN/OU illegal for user
) (
	input  logic            strob1,
	input  logic            rst_n,
	input  logic [0:ir_w-1] w,	// W bus
	input  logic            w_ir,	// W->IR strobe
	input  logic            si1,	// Invalidate on load
	input  logic            q,	// System flag
	input  logic [0:r0_w-1] r0,	// R0 flags
	output logic [0:ir_w-1] ir,
	output cls_t            cls,
	output logic            xi,
	output logic            nef,
	output phase_t          phase,
	output logic            busy,
	output logic            ekc
);

	logic             start;
	logic [fld_w-1:0] fld_a;
	logic [fld_w-1:0] fld_b;
	logic [fld_w-1:0] fld_c;

	instr_decode #(
		.io_user_illegal(io_user_illegal)
	) decode_i (
		.strob1(strob1),
		.rst_n (rst_n),
		.w     (w),
		.w_ir  (w_ir),
		.si1   (si1),
		.q     (q),
		.busy  (busy),
		.ir    (ir),
		.start (start),
		.cls   (cls),
		.fld_a (fld_a),
		.fld_b (fld_b),
		.fld_c (fld_c),
		.xi    (xi)
	);

	jump_cond jump_i (
		.cls  (cls),
		.fld_a(fld_a),
		.r0   (r0),
		.xi   (xi),
		.nef  (nef)
	);

	phase_seq seq_i (
		.strob1(strob1),
		.rst_n (rst_n),
		.start (start),
		.cls   (cls),
		.fld_b (fld_b),
		.fld_c (fld_c),
		.nef   (nef),
		.phase (phase),
		.busy  (busy),
		.ekc   (ekc)
	);

endmodule

// ==== logic/phase_seq.sv ====
`timescale 1ns/1ps
/*
	Execution phase FSM for WP, WA, WE and cycle end
	Entry is chosen on start from nef, class and fields B and C
	One instruction at a time, each phase lasts a single cycle
*/

module phase_seq import pd_pkg::*; (
	input  logic             strob1,
	input  logic             rst_n,
	input  logic             start,	// Load accepted last edge
	input  cls_t             cls,
	input  logic [fld_w-1:0] fld_b,
	input  logic [fld_w-1:0] fld_c,
	input  logic             nef,
	output phase_t           phase,
	output logic             busy,	// Phase is not idle
	output logic             ekc	// Cycle end
);

	phase_t ph_next;
	logic   need_wp;	// Argument in the next word
	logic   need_wa;	// B-modification present

	assign need_wp = ((cls == CLS_ARG) | (cls == CLS_JUMP)) & (fld_c == '0);
	assign need_wa = (fld_b != '0);

	always_comb begin
		ph_next = phase;
		case (phase)
			PH_IDLE: begin
				if (start) begin
					if (nef)
						ph_next = PH_END;	// Straight to end
					else if (need_wp)
						ph_next = PH_WP;
					else if (need_wa)
						ph_next = PH_WA;
					else
						ph_next = PH_WE;
				end
			end
			PH_WP: begin
				ph_next = need_wa ? PH_WA : PH_WE;	// Skip WA when B is 0
			end
			PH_WA: begin
				ph_next = PH_WE;
			end
			PH_WE: begin
				ph_next = PH_END;
			end
			PH_END: begin
				ph_next = PH_IDLE;	// Ready for next W->IR
			end
			default: begin
				ph_next = PH_IDLE;	// Unused encodings recover
			end
		endcase
	end

	always_ff @(posedge strob1 or negedge rst_n) begin
		if (!rst_n) begin
			phase <= PH_IDLE;
			busy  <= 1'b0;
			ekc   <= 1'b0;
		end else begin
			phase <= ph_next;
			busy  <= (ph_next != PH_IDLE);	// Tracks phase exactly
			ekc   <= (ph_next == PH_END);
		end
	end

endmodule

// ==== logic/jump_cond.sv ====
`timescale 1ns/1ps
/*
	Jump condition and ineffective flag, purely combinational
	r0 is read directly, hold it stable while the jump is in IR
*/

module jump_cond import pd_pkg::*; (
	input  cls_t             cls,
	input  logic [fld_w-1:0] fld_a,	// Condition select
	input  logic [0:r0_w-1]  r0,	// R0 flags
	input  logic             xi,
	output logic             nef	// Instruction is ineffective
);

	logic taken;	// Selected condition holds

	always_comb begin
		case (fld_a)
			3'd0:    taken = 1'b1;	// UJ
			3'd1:    taken = r0[f_l];	// JL
			3'd2:    taken = r0[f_e];	// JE
			3'd3:    taken = r0[f_g];	// JG
			3'd4:    taken = r0[f_z];	// JZ
			3'd5:    taken = r0[f_m];	// JM
			3'd6:    taken = ~r0[f_e];	// JN, inverted E
			default: taken = 1'b1;	// LJ
		endcase
	end

	// Illegal always ineffective, non-jumps never fail on condition
	assign nef = xi | ((cls == CLS_JUMP) & ~taken);

endmodule

// ==== logic/instr_decode.sv ====
`timescale 1ns/1ps
/*
	IR with W->IR load and SI1 invalidate, field split and class decode
	A load is ignored while busy or in the cycle right after a load
	xi is combinational from IR and q, so q must be stable per instruction
*/

module instr_decode import pd_pkg::*; #(
	parameter bit io_user_illegal = 1'b1	// IN/OU illegal in user mode
) (
	input  logic            strob1,
	input  logic            rst_n,
	input  logic [0:ir_w-1] w,	// W bus
	input  logic            w_ir,	// Load strobe
	input  logic            si1,	// Invalidate on load
	input  logic            q,	// System flag, 1 is user mode
	input  logic            busy,	// From the sequencer
	output logic [0:ir_w-1] ir,
	output logic            start,	// One cycle after an accepted load
	output cls_t            cls,
	output logic [fld_w-1:0] fld_a,
	output logic [fld_w-1:0] fld_b,
	output logic [fld_w-1:0] fld_c,
	output logic            xi	// Illegal instruction
);

	logic            load;	// Accepted W->IR
	logic [0:op_w-1] op;	// Opcode field

	// start covers the gap before busy rises
	assign load = w_ir & ~busy & ~start;

	always_ff @(posedge strob1 or negedge rst_n) begin
		if (!rst_n) begin
			ir <= '0;
		end else if (load) begin
			ir[0:1]      <= si1 ? 2'b00 : w[0:1];	// Forces opcode below 020
			ir[2:ir_w-1] <= w[2:ir_w-1];
		end
	end

	always_ff @(posedge strob1 or negedge rst_n) begin
		if (!rst_n) begin
			start <= 1'b0;
		end else begin
			start <= load;	// Single pulse per load
		end
	end

	// Field split
	assign op    = ir[0:5];
	assign fld_a = ir[7:9];	// Register or jump condition
	assign fld_b = ir[10:12];	// B-modification register
	assign fld_c = ir[13:15];	// 0 means argument in next word

	// Opcode to class
	always_comb begin
		case (op) inside
			[6'o20:6'o57]: cls = CLS_ARG;	// Two-word or register argument
			[6'o60:6'o67]: cls = CLS_SHORT;	// KA1 group
			op_jump:       cls = CLS_JUMP;
			op_sys:        cls = CLS_SYS;
			op_in, op_ou:  cls = CLS_IO;
			default:       cls = CLS_ILL;	// Includes all of 000..017
		endcase
	end

	// Illegal in class, or privileged in user mode
	always_comb begin
		xi = 1'b0;
		case (cls)
			CLS_ILL: xi = 1'b1;
			CLS_SYS: xi = q;	// System group is supervisor only
			CLS_IO:  xi = q & io_user_illegal;	// Strap selectable
			default: xi = 1'b0;
		endcase
	end

endmodule

// ==== logic/pd_pkg.sv ====
/*
	Shared widths, encodings and opcodes of the instruction decoder
	Bit 0 is the MSB of every vector, as on the W bus
	Only the reduced six-class instruction set is encoded here
*/

package pd_pkg;

	localparam int ir_w  = 16;	// Instruction word
	localparam int r0_w  = 9;	// R0 flags Z M V C L E G Y X
	localparam int op_w  = 6;	// Opcode field, IR bits 0:5
	localparam int fld_w = 3;	// A, B and C fields

	// R0 flag positions used by the jump unit
	localparam int f_z = 0;
	localparam int f_m = 1;
	localparam int f_l = 4;
	localparam int f_e = 5;
	localparam int f_g = 6;

	// Single opcodes, named by octal value
	localparam logic [op_w-1:0] op_jump = 6'o70;	// Conditional jump group
	localparam logic [op_w-1:0] op_sys  = 6'o73;	// System group
	localparam logic [op_w-1:0] op_in   = 6'o74;	// IN
	localparam logic [op_w-1:0] op_ou   = 6'o75;	// OU

	typedef enum logic [2:0] {
		CLS_ARG   = 3'd0,	// Normal argument, 020..057
		CLS_SHORT = 3'd1,	// Short argument, 060..067
		CLS_JUMP  = 3'd2,	// 070
		CLS_SYS   = 3'd3,	// 073
		CLS_IO    = 3'd4,	// 074..075
		CLS_ILL   = 3'd5	// Anything else
	} cls_t;

	typedef enum logic [2:0] {
		PH_IDLE = 3'd0,	// Waiting for W->IR
		PH_WP   = 3'd1,	// Argument word fetch
		PH_WA   = 3'd2,	// B-modification
		PH_WE   = 3'd3,	// Execute
		PH_END  = 3'd4	// Cycle end
	} phase_t;

endpackage
